//--- hdl/load_cache_config.svh
/*
 * Width, line and way constants for the load-side cache controller.
 * Include this wherever a macro below is used. The package has the types.
 */

`ifndef LOAD_CACHE_CONFIG_SVH
`define LOAD_CACHE_CONFIG_SVH

// Address and data port widths
`define LC_XLEN        32
`define LC_PORT_WIDTH  32

// Cache geometry
`define LC_BLOCK_WORDS 4
`define LC_WAYS        4
`define LC_INDEX_BITS  6

// Start value of the victim LFSR, never the all ones lockup state
`define LC_LFSR_SEED   3'b010

// Bit positions inside the cache field enable mask
`define LC_EN_DATA     0
`define LC_EN_DIRTY    1
`define LC_EN_VALID    2
`define LC_EN_TAG      3

`endif

//--- hdl/load_cache_pkg.sv
/*
 * Shared types of the load cache controller.
 * Modules import it with a wildcard in their header.
 */

`include "load_cache_config.svh"

package load_cache_pkg;

    // One data word on the memory, cache and store-buffer ports
    typedef logic [`LC_PORT_WIDTH-1:0] word_t;

    // Byte address laid out as tag, index, word select and byte offset
    typedef logic [`LC_XLEN-1:0] addr_t;

    // Word within a cache line
    typedef logic [$clog2(`LC_BLOCK_WORDS)-1:0] word_sel_t;

    // One-hot word number that comes with every memory beat
    typedef logic [`LC_BLOCK_WORDS-1:0] word_onehot_t;

    // Word counter, one bit wider so it can hold a full line
    typedef logic [$clog2(`LC_BLOCK_WORDS):0] word_cnt_t;

    // One-hot way select
    typedef logic [`LC_WAYS-1:0] way_onehot_t;

    // Word address sent to the cache, the byte offset is dropped
    typedef logic [`LC_XLEN-$clog2(`LC_PORT_WIDTH/8)-1:0] cache_addr_t;

    // Field enables, indexed by the LC_EN_* positions
    typedef logic [3:0] cache_enable_t;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE_TAG,
        DATA_STABLE,
        MEMORY_REQUEST,
        DIRTY_CHECK,
        READ_CACHE,
        WRITE_BACK,
        ALLOCATE
    } lc_state_t;

endpackage : load_cache_pkg

//--- hdl/refill_buffer.sv
/*
 * Line buffer for a cache refill. Memory beats land here in any order
 * and are handed to the controller in word order for allocation.
 */

`timescale 1ns/1ps

`include "load_cache_config.svh"

module refill_buffer import load_cache_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         mem_valid_i,
    input  word_onehot_t mem_word_num_i,
    input  word_t        mem_data_i,
    input  logic         refill_pop_i,
    input  logic         refill_clear_i,
    output logic         word_avail_o,
    output word_t        head_word_o
);

    word_t        line_q [`LC_BLOCK_WORDS];
    word_onehot_t got_q;
    word_cnt_t    recv_cnt_q;
    word_cnt_t    alloc_cnt_q;

    // Payload storage, the one-hot word number picks the slot
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `LC_BLOCK_WORDS; i++) begin
            if (mem_valid_i && mem_word_num_i[i]) begin
                line_q[i] <= mem_data_i;
            end
        end
    end

    // Received count and the mask of words already in the line
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || refill_clear_i) begin
            recv_cnt_q <= '0;
            got_q      <= '0;
        end else if (mem_valid_i) begin
            recv_cnt_q <= recv_cnt_q + 1'b1;
            got_q      <= got_q | mem_word_num_i;
        end
    end

    // Words already written into the cache
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || refill_clear_i) begin
            alloc_cnt_q <= '0;
        end else if (refill_pop_i) begin
            alloc_cnt_q <= alloc_cnt_q + 1'b1;
        end
    end

    // Beats come out of order, so the next word in line must also be present
    assign word_avail_o = (alloc_cnt_q < recv_cnt_q) && got_q[word_sel_t'(alloc_cnt_q)];
    assign head_word_o  = line_q[word_sel_t'(alloc_cnt_q)];

    // A line has four words, a fifth beat before the clear is a protocol error
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        recv_cnt_q <= word_cnt_t'(`LC_BLOCK_WORDS));

endmodule : refill_buffer

//--- hdl/victim_way_lfsr.sv
/*
 * Random victim way for replacement. A three-bit XNOR LFSR steps every
 * clock and holds its value while the controller freezes it.
 */

`timescale 1ns/1ps

`include "load_cache_config.svh"

module victim_way_lfsr import load_cache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        lfsr_freeze_i,
    output way_onehot_t victim_way_o
);

    logic [2:0] lfsr_q;
    logic       feedback;

    // Taps at bits 2 and 1 give the maximal seven-state sequence
    assign feedback = ~(lfsr_q[2] ^ lfsr_q[1]);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q <= `LC_LFSR_SEED;
        end else if (!lfsr_freeze_i) begin
            lfsr_q <= {lfsr_q[1:0], feedback};
        end
    end

    // Low two bits pick one of the four ways
    assign victim_way_o = way_onehot_t'(1) << lfsr_q[1:0];

    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot(victim_way_o));

endmodule : victim_way_lfsr

//--- hdl/load_cache_fsm.sv
/*
 * Load-side controller FSM. Handles forwarding from the store unit and
 * store buffer, the tag compare, and on a miss the write-back of a dirty
 * victim followed by the allocation of the refilled line.
 */

`timescale 1ns/1ps

`include "load_cache_config.svh"

module load_cache_fsm import load_cache_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    // Load unit
    input  logic          load_read_i,
    input  addr_t         load_addr_i,
    // Store unit
    input  addr_t         st_unit_addr_i,
    input  word_t         st_unit_data_i,
    input  logic          st_unit_idle_i,
    // Store buffer
    input  logic          sb_match_i,
    input  word_t         sb_data_i,
    input  logic          sb_full_i,
    input  logic          sb_port_idle_i,
    // External memory
    input  logic          mem_ack_i,
    // Cache
    input  logic          cache_hit_i,
    input  logic          cache_dirty_i,
    input  word_t         cache_data_i,
    input  word_t         cache_wb_data_i,
    input  logic          port0_granted_i,
    // Refill buffer
    input  logic          word_avail_i,
    input  word_t         head_word_i,
    output logic          stall_pipeline_o,
    output logic          processor_request_o,
    output logic          sb_push_o,
    output word_t         data_o,
    output logic          data_valid_o,
    output cache_addr_t   cache_addr_o,
    output logic          cache_port1_read_o,
    output logic          cache_port0_write_o,
    output cache_enable_t cache_port1_enable_o,
    output cache_enable_t cache_port0_enable_o,
    output logic          cache_dirty_o,
    output logic          cache_valid_o,
    output logic          port0_request_o,
    output logic          lfsr_freeze_o,
    output logic          refill_pop_o,
    output logic          refill_clear_o,
    output logic          idle_o
);

    lc_state_t   state_q, state_d;
    word_sel_t   word_sel_q, word_sel_d;
    word_t       load_word_q, load_word_d;
    cache_addr_t req_word_addr;
    cache_addr_t line_word_addr;
    word_sel_t   req_sel;
    logic        st_unit_match;
    logic        sb_ready;
    logic        last_word;

    // --------------------------------------------------
    // Address decode and forwarding checks
    // --------------------------------------------------

    assign req_word_addr  = load_addr_i[`LC_XLEN-1:$clog2(`LC_PORT_WIDTH/8)];
    assign req_sel        = req_word_addr[$bits(word_sel_t)-1:0];

    // During a miss the word select comes from the line walk counter
    assign line_word_addr = {req_word_addr[$bits(cache_addr_t)-1:$bits(word_sel_t)], word_sel_q};

    // The store unit holds the newest data, so it wins over the store buffer
    assign st_unit_match  = (st_unit_addr_i == load_addr_i) && !st_unit_idle_i;

    assign sb_ready       = !sb_full_i && sb_port_idle_i;
    assign last_word      = (word_sel_q == word_sel_t'(`LC_BLOCK_WORDS - 1));

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            word_sel_q <= '0;
        end else begin
            state_q    <= state_d;
            word_sel_q <= word_sel_d;
        end
    end

    always_ff @(posedge clk_i) begin
        load_word_q <= load_word_d;
    end

    // --------------------------------------------------
    // Next state and outputs
    // --------------------------------------------------

    always_comb begin
        state_d              = state_q;
        word_sel_d           = word_sel_q;
        load_word_d          = load_word_q;
        stall_pipeline_o     = 1'b0;
        lfsr_freeze_o        = 1'b0;
        processor_request_o  = 1'b0;
        sb_push_o            = 1'b0;
        data_o               = '0;
        data_valid_o         = 1'b0;
        cache_addr_o         = req_word_addr;
        cache_port1_read_o   = 1'b0;
        cache_port0_write_o  = 1'b0;
        cache_port1_enable_o = '0;
        cache_port0_enable_o = '0;
        cache_dirty_o        = 1'b0;
        cache_valid_o        = 1'b0;
        port0_request_o      = 1'b0;
        refill_pop_o         = 1'b0;
        refill_clear_o       = 1'b0;

        // Every miss state stalls the front end and keeps the victim way fixed
        if (state_q inside {MEMORY_REQUEST, DIRTY_CHECK, READ_CACHE, WRITE_BACK, ALLOCATE}) begin
            stall_pipeline_o = 1'b1;
            lfsr_freeze_o    = 1'b1;
            cache_addr_o     = line_word_addr;
        end

        case (state_q)
            IDLE: begin
                if (load_read_i) begin
                    // Read every field so the tag compare can run next cycle
                    cache_port1_read_o   = 1'b1;
                    cache_port1_enable_o = '1;
                    state_d              = COMPARE_TAG;
                    if (st_unit_match) begin
                        load_word_d = st_unit_data_i;
                        state_d     = DATA_STABLE;
                    end else if (sb_match_i) begin
                        load_word_d = sb_data_i;
                        state_d     = DATA_STABLE;
                    end
                end
            end

            COMPARE_TAG: begin
                if (cache_hit_i) begin
                    load_word_d = cache_data_i;
                    state_d     = DATA_STABLE;
                end else begin
                    // The stall starts here, so the victim must freeze here too
                    stall_pipeline_o = 1'b1;
                    lfsr_freeze_o    = 1'b1;
                    state_d          = MEMORY_REQUEST;
                end
            end

            DATA_STABLE: begin
                data_o       = load_word_q;
                data_valid_o = 1'b1;
                state_d      = IDLE;
            end

            MEMORY_REQUEST: begin
                processor_request_o = 1'b1;
                word_sel_d          = '0;
                if (mem_ack_i) begin
                    state_d = READ_CACHE;
                end
            end

            READ_CACHE: begin
                // Word 0 also brings the dirty bit of the victim
                cache_port1_read_o                = 1'b1;
                cache_port1_enable_o[`LC_EN_DATA] = 1'b1;
                if (word_sel_q == '0) begin
                    cache_port1_enable_o[`LC_EN_DIRTY] = 1'b1;
                    state_d                            = DIRTY_CHECK;
                end else begin
                    state_d = WRITE_BACK;
                end
            end

            DIRTY_CHECK: begin
                if (!cache_dirty_i) begin
                    state_d = ALLOCATE;
                end else if (sb_ready) begin
                    sb_push_o  = 1'b1;
                    data_o     = cache_wb_data_i;
                    word_sel_d = word_sel_q + 1'b1;
                    state_d    = READ_CACHE;
                end
            end

            WRITE_BACK: begin
                // Hold here while the store buffer pushes back
                if (sb_ready) begin
                    sb_push_o = 1'b1;
                    data_o    = cache_wb_data_i;
                    if (last_word) begin
                        word_sel_d = '0;
                        state_d    = ALLOCATE;
                    end else begin
                        word_sel_d = word_sel_q + 1'b1;
                        state_d    = READ_CACHE;
                    end
                end
            end

            ALLOCATE: begin
                port0_request_o = 1'b1;
                if (port0_granted_i && word_avail_i) begin
                    cache_port0_write_o = 1'b1;
                    refill_pop_o        = 1'b1;
                    data_o              = head_word_i;
                    // The load gets its word as it goes by
                    data_valid_o        = (word_sel_q == req_sel);

                    // Tag and status are written once, with the first word
                    if (word_sel_q == '0) begin
                        cache_port0_enable_o = '1;
                        cache_valid_o        = 1'b1;
                    end else begin
                        cache_port0_enable_o[`LC_EN_DATA] = 1'b1;
                    end

                    if (last_word) begin
                        refill_clear_o = 1'b1;
                        state_d        = IDLE;
                    end else begin
                        word_sel_d = word_sel_q + 1'b1;
                    end
                end
            end

            default: state_d = IDLE;
        endcase
    end

    assign idle_o = (state_d == IDLE);

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // No push may land in a full or busy store buffer
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sb_push_o |-> !sb_full_i && sb_port_idle_i);

    // Once raised, the stall holds through the whole miss until idle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_pipeline_o && !idle_o) |=> stall_pipeline_o);

endmodule : load_cache_fsm

//--- hdl/load_cache_ctrl.sv
/*
 * Top level of the load cache controller. Connects the FSM, the refill
 * line buffer and the victim LFSR to the core, memory and cache ports.
 */

`timescale 1ns/1ps

module load_cache_ctrl import load_cache_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          load_read_i,
    input  addr_t         load_addr_i,
    input  addr_t         st_unit_addr_i,
    input  word_t         st_unit_data_i,
    input  logic          st_unit_idle_i,
    input  logic          sb_match_i,
    input  word_t         sb_data_i,
    input  logic          sb_full_i,
    input  logic          sb_port_idle_i,
    input  logic          mem_ack_i,
    input  logic          mem_valid_i,
    input  word_onehot_t  mem_word_num_i,
    input  word_t         mem_data_i,
    input  logic          cache_hit_i,
    input  logic          cache_dirty_i,
    input  word_t         cache_data_i,
    input  word_t         cache_wb_data_i,
    input  logic          port0_granted_i,
    output logic          stall_pipeline_o,
    output logic          processor_request_o,
    output logic          sb_push_o,
    output word_t         data_o,
    output logic          data_valid_o,
    output cache_addr_t   cache_addr_o,
    output logic          cache_port1_read_o,
    output logic          cache_port0_write_o,
    output cache_enable_t cache_port1_enable_o,
    output cache_enable_t cache_port0_enable_o,
    output logic          cache_dirty_o,
    output logic          cache_valid_o,
    output logic          port0_request_o,
    output way_onehot_t   victim_way_o,
    output logic          idle_o
);

    // Control from the FSM to the helpers and status coming back
    logic  lfsr_freeze;
    logic  refill_pop;
    logic  refill_clear;
    logic  word_avail;
    word_t head_word;

    load_cache_fsm fsm_inst (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .load_read_i          (load_read_i),
        .load_addr_i          (load_addr_i),
        .st_unit_addr_i       (st_unit_addr_i),
        .st_unit_data_i       (st_unit_data_i),
        .st_unit_idle_i       (st_unit_idle_i),
        .sb_match_i           (sb_match_i),
        .sb_data_i            (sb_data_i),
        .sb_full_i            (sb_full_i),
        .sb_port_idle_i       (sb_port_idle_i),
        .mem_ack_i            (mem_ack_i),
        .cache_hit_i          (cache_hit_i),
        .cache_dirty_i        (cache_dirty_i),
        .cache_data_i         (cache_data_i),
        .cache_wb_data_i      (cache_wb_data_i),
        .port0_granted_i      (port0_granted_i),
        .word_avail_i         (word_avail),
        .head_word_i          (head_word),
        .stall_pipeline_o     (stall_pipeline_o),
        .processor_request_o  (processor_request_o),
        .sb_push_o            (sb_push_o),
        .data_o               (data_o),
        .data_valid_o         (data_valid_o),
        .cache_addr_o         (cache_addr_o),
        .cache_port1_read_o   (cache_port1_read_o),
        .cache_port0_write_o  (cache_port0_write_o),
        .cache_port1_enable_o (cache_port1_enable_o),
        .cache_port0_enable_o (cache_port0_enable_o),
        .cache_dirty_o        (cache_dirty_o),
        .cache_valid_o        (cache_valid_o),
        .port0_request_o      (port0_request_o),
        .lfsr_freeze_o        (lfsr_freeze),
        .refill_pop_o         (refill_pop),
        .refill_clear_o       (refill_clear),
        .idle_o               (idle_o)
    );

    // Memory beats go straight into the line buffer
    refill_buffer refill_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mem_valid_i    (mem_valid_i),
        .mem_word_num_i (mem_word_num_i),
        .mem_data_i     (mem_data_i),
        .refill_pop_i   (refill_pop),
        .refill_clear_i (refill_clear),
        .word_avail_o   (word_avail),
        .head_word_o    (head_word)
    );

    victim_way_lfsr lfsr_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .lfsr_freeze_i (lfsr_freeze),
        .victim_way_o  (victim_way_o)
    );

endmodule : load_cache_ctrl

//--- dv/tb_load_cache_ctrl.sv
/*
 * Self-checking testbench for the load cache controller. Each line of the
 * test file is one load; cache, memory and store-buffer models answer it.
 */

`timescale 1ns/1ps

module tb_load_cache_ctrl import load_cache_pkg::*; ();

    logic          clk_i;
    logic          rst_n_i;
    logic          load_read_i;
    addr_t         load_addr_i;
    addr_t         st_unit_addr_i;
    word_t         st_unit_data_i;
    logic          st_unit_idle_i;
    logic          sb_match_i;
    word_t         sb_data_i;
    logic          sb_full_i;
    logic          sb_port_idle_i;
    logic          mem_ack_i;
    logic          mem_valid_i;
    word_onehot_t  mem_word_num_i;
    word_t         mem_data_i;
    logic          cache_hit_i;
    logic          cache_dirty_i;
    word_t         cache_data_i;
    word_t         cache_wb_data_i;
    logic          port0_granted_i;
    logic          stall_pipeline_o;
    logic          processor_request_o;
    logic          sb_push_o;
    word_t         data_o;
    logic          data_valid_o;
    cache_addr_t   cache_addr_o;
    logic          cache_port1_read_o;
    logic          cache_port0_write_o;
    cache_enable_t cache_port1_enable_o;
    cache_enable_t cache_port0_enable_o;
    logic          cache_dirty_o;
    logic          cache_valid_o;
    logic          port0_request_o;
    way_onehot_t   victim_way_o;
    logic          idle_o;

    // Test table filled from the data file
    int          modes[$];
    logic [31:0] addrs[$];
    logic [31:0] bases[$];
    int          num_tests = 0;
    logic [31:0] rng_state;

    load_cache_ctrl load_cache_ctrl_inst (.*);

    always #20 clk_i = ~clk_i;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    // Xorshift32 step; all random stimulus comes from here
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Lines starting with # are column notes and are skipped
    task automatic load_tests();
        int          fd;
        int          mode;
        logic [31:0] addr;
        logic [31:0] base;
        string       line;
        fd = $fopen("dv/load_cache_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the test file dv/load_cache_tests.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %h %h", mode, addr, base) == 3) begin
                    modes.push_back(mode);
                    addrs.push_back(addr);
                    bases.push_back(base);
                end
            end
        end
        $fclose(fd);
        if (modes.size() == 0) begin
            fail_run("The test file holds no test lines");
        end
        num_tests = modes.size();
    endtask

    // --------------------------------------------------
    // One load with cache, memory and store-buffer models
    // --------------------------------------------------

    task automatic run_load(input int mode, input logic [31:0] addr, input logic [31:0] base);
        int          cyc;
        int          writes;
        int          pushes;
        int          valids;
        int          beat;
        int          gap;
        int          ack_delay;
        int          i;
        int          j;
        int          tmp;
        int          order[4];
        bit          stall_seen;
        bit          req_seen;
        bit          ack_issued;
        bit          acked;
        bit          ack_next;
        bit          beat_next;
        bit          done;
        logic [1:0]  req_sel;
        logic [1:0]  wb_sel;
        logic [31:0] exp_data;
        way_onehot_t victim;

        cyc        = 0;
        writes     = 0;
        pushes     = 0;
        valids     = 0;
        beat       = 0;
        gap        = 0;
        ack_delay  = 0;
        stall_seen = 0;
        req_seen   = 0;
        ack_issued = 0;
        acked      = 0;
        ack_next   = 0;
        beat_next  = 0;
        done       = 0;
        wb_sel     = '0;
        victim     = '0;
        req_sel    = addr[3:2];

        // Memory returns the line in a shuffled word order
        for (i = 0; i < 4; i++) begin
            order[i] = i;
        end
        for (i = 3; i > 0; i--) begin
            j        = int'(next_rand() % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end

        case (mode)
            0: exp_data = base;
            1: exp_data = ~base;
            2: exp_data = base ^ 32'h0f0f_0f0f;
            default: exp_data = base + 32'(req_sel);
        endcase

        @(posedge clk_i);
        #2;
        load_read_i    = 1'b1;
        load_addr_i    = addr;
        st_unit_addr_i = addr;
        st_unit_data_i = ~base;
        // Mode 1 raises both matches so the store unit must win
        st_unit_idle_i = (mode != 1);
        sb_match_i     = (mode == 1 || mode == 2);
        sb_data_i      = base ^ 32'h0f0f_0f0f;
        cache_hit_i    = (mode <= 2);
        cache_dirty_i  = (mode == 4);
        cache_data_i   = base;
        mem_ack_i      = 1'b0;
        mem_valid_i    = 1'b0;

        while (!done) begin
            @(negedge clk_i);
            cyc++;
            if (!$onehot(victim_way_o)) begin
                fail_run("victim_way_o is not one-hot");
            end
            if (cache_port1_read_o) begin
                wb_sel = cache_addr_o[1:0];
                if (stall_pipeline_o) begin
                    // Miss reads walk the victim line and word 0 also fetches the dirty bit
                    check_value("cache_addr_o line on read", 32'(cache_addr_o[29:2]),
                                32'(addr[31:4]));
                    check_value("cache_port1_enable_o on line read",
                                32'(cache_port1_enable_o), (wb_sel == 2'd0) ? 32'h3 : 32'h1);
                end else begin
                    check_value("cache_addr_o on request read", 32'(cache_addr_o),
                                32'(addr[31:2]));
                    check_value("cache_port1_enable_o on request read",
                                32'(cache_port1_enable_o), 32'hf);
                end
            end

            if (cache_port0_write_o) begin
                check_value("port0_granted_i at write", 32'(port0_granted_i), 1);
                check_value("port0_request_o at write", 32'(port0_request_o), 1);
                check_value("cache_addr_o line on write", 32'(cache_addr_o[29:2]),
                            32'(addr[31:4]));
                check_value("cache_addr_o word select", 32'(cache_addr_o[1:0]), writes);
                check_value("data_o on port 0 write", data_o, base + writes);
                // The first word carries tag, valid and a clean dirty bit with the data
                if (writes == 0) begin
                    check_value("cache_port0_enable_o on first write",
                                32'(cache_port0_enable_o), 32'hf);
                    check_value("cache_valid_o on first write", 32'(cache_valid_o), 1);
                    check_value("cache_dirty_o on first write", 32'(cache_dirty_o), 0);
                end else begin
                    check_value("cache_port0_enable_o on later write",
                                32'(cache_port0_enable_o), 32'h1);
                end
                writes++;
            end
            if (data_valid_o) begin
                valids++;
                check_value("data_o with data_valid_o", data_o, exp_data);
                if (mode <= 2) begin
                    check_value("data_valid_o latency", cyc, (mode == 0) ? 3 : 2);
                    done = 1;
                end else begin
                    check_value("word written with data_valid_o", writes - 1, 32'(req_sel));
                end
            end
            if (sb_push_o) begin
                check_value("sb_full_i at push", 32'(sb_full_i), 0);
                check_value("sb_port_idle_i at push", 32'(sb_port_idle_i), 1);
                check_value("data_o on push", data_o, base ^ pushes);
                pushes++;
            end

            // Memory request is held until the acknowledge cycle
            if (acked) begin
                check_value("processor_request_o", 32'(processor_request_o), 0);
            end else if (req_seen) begin
                check_value("processor_request_o", 32'(processor_request_o), 1);
            end
            if (processor_request_o && !req_seen) begin
                req_seen  = 1;
                ack_delay = int'(next_rand() % 3);
            end
            if (mem_ack_i) begin
                acked = 1;
            end
            if (req_seen && !ack_issued) begin
                if (ack_delay == 0) begin
                    ack_next   = 1;
                    ack_issued = 1;
                end else begin
                    ack_delay--;
                end
            end
            if (acked && beat < 4) begin
                if (gap == 0) begin
                    beat_next = 1;
                    gap       = int'(next_rand() % 3);
                end else begin
                    gap--;
                end
            end

            // Stall and victim stay fixed from the first miss cycle to idle
            if (mode <= 2) begin
                check_value("stall_pipeline_o", 32'(stall_pipeline_o), 0);
                check_value("port0_request_o", 32'(port0_request_o), 0);
            end else if (stall_pipeline_o && !stall_seen) begin
                // The miss is known in the tag compare cycle after the request cycle
                check_value("stall_pipeline_o start cycle", cyc, 2);
                stall_seen = 1;
                victim     = victim_way_o;
            end
            if (stall_seen) begin
                check_value("stall_pipeline_o", 32'(stall_pipeline_o), 1);
                check_value("victim_way_o", 32'(victim_way_o), 32'(victim));
                if (idle_o) begin
                    done = 1;
                end
            end

            if (!done) begin
                @(posedge clk_i);
                #2;
                load_read_i     = 1'b0;
                sb_match_i      = 1'b0;
                st_unit_idle_i  = 1'b1;
                sb_full_i       = (next_rand() % 4) == 0;
                sb_port_idle_i  = (next_rand() % 4) != 0;
                port0_granted_i = (next_rand() % 4) != 0;
                cache_wb_data_i = base ^ 32'(wb_sel);
                mem_ack_i       = ack_next;
                ack_next        = 0;
                mem_valid_i     = beat_next;
                if (beat_next) begin
                    mem_word_num_i = 4'b0001 << order[beat];
                    mem_data_i     = base + order[beat];
                    beat++;
                end
                beat_next = 0;
            end
        end

        check_value("data_valid_o count", valids, 1);
        check_value("store-buffer push count", pushes, (mode == 4) ? 4 : 0);
        check_value("port 0 write count", writes, (mode >= 3) ? 4 : 0);
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------

    initial begin
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        load_read_i     = 1'b0;
        load_addr_i     = '0;
        st_unit_addr_i  = '0;
        st_unit_data_i  = '0;
        st_unit_idle_i  = 1'b1;
        sb_match_i      = 1'b0;
        sb_data_i       = '0;
        sb_full_i       = 1'b0;
        sb_port_idle_i  = 1'b1;
        mem_ack_i       = 1'b0;
        mem_valid_i     = 1'b0;
        mem_word_num_i  = '0;
        mem_data_i      = '0;
        cache_hit_i     = 1'b0;
        cache_dirty_i   = 1'b0;
        cache_data_i    = '0;
        cache_wb_data_i = '0;
        port0_granted_i = 1'b0;
        rng_state       = 32'hac03;
        load_tests();

        repeat (15) @(posedge clk_i);
        @(negedge clk_i);
        check_value("idle_o in reset", 32'(idle_o), 1);
        check_value("stall_pipeline_o in reset", 32'(stall_pipeline_o), 0);
        check_value("processor_request_o in reset", 32'(processor_request_o), 0);
        check_value("sb_push_o in reset", 32'(sb_push_o), 0);
        check_value("data_valid_o in reset", 32'(data_valid_o), 0);
        check_value("port0_request_o in reset", 32'(port0_request_o), 0);
        check_value("cache_port0_write_o in reset", 32'(cache_port0_write_o), 0);
        check_value("cache_port1_read_o in reset", 32'(cache_port1_read_o), 0);
        @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        for (int t = 0; t < num_tests; t++) begin
            run_load(modes[t], addrs[t], bases[t]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Budget of 400 cycles per test line plus reset
    initial begin
        wait (num_tests > 0);
        repeat (400 * (num_tests + 1)) @(posedge clk_i);
        fail_run($sformatf("Timeout: %0d loads did not finish in %0d cycles",
                           num_tests, 400 * (num_tests + 1)));
    end

endmodule : tb_load_cache_ctrl

//--- dv/load_cache_tests.txt
# mode: 0 hit, 1 store-unit forward, 2 store-buffer forward, 3 clean miss, 4 dirty miss
# columns: mode (decimal), load address (hex), base data (hex)
0 00001000 11223344
0 0000100c a5a5a5a5
1 00002044 cafe0001
2 00003048 0badf00d
3 00004000 10000000
3 0000410c 20000000
4 00005104 30000000
4 00005208 40000000
1 0000600c 76543210
3 00007004 fffffffe
4 0000800c 50505050
2 00009000 deadbeef
0 0000a008 01234567
4 0000b000 6000000f
3 0000c008 7ffffff0

//--- load_cache_ctrl.f
+incdir+hdl
hdl/load_cache_pkg.sv
hdl/refill_buffer.sv
hdl/victim_way_lfsr.sv
hdl/load_cache_fsm.sv
hdl/load_cache_ctrl.sv
dv/tb_load_cache_ctrl.sv

//--- Makefile
# Verilator build and run for the load cache controller

VERILATOR ?= verilator
TOP       ?= tb_load_cache_ctrl
RTL_TOP   ?= load_cache_ctrl
FILELIST  ?= load_cache_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
